/* common/fpPkg.sv */
// IEEE 754 single precision format definitions shared by the function units.
// Holds field types, the exponent bias and the signed integer limits.

package fpPkg;

	// ==================================================
	// Bit pattern types
	// ==================================================

	// Raw float word: sign, biased exponent, stored fraction
	typedef logic [31:0] fpWord;

	// Biased exponent field
	typedef logic [7:0] expField;

	// Stored fraction, the hidden leading one is not part of it
	typedef logic [22:0] manField;

	// Two's complement integer result of a conversion
	typedef logic signed [31:0] intWord;

	// ==================================================
	// Format constants
	// ==================================================

	// Exponent value that encodes a scale of 2^0
	localparam int expBias = 127;

	// Number of stored fraction bits
	localparam int fracBits = 23;

	// Width of the converted integer
	localparam int intBits = 32;

	// All ones in the exponent marks infinity or NaN
	localparam expField expSpecial = 8'hFF;

	// Saturation limits used when a conversion is out of range
	localparam intWord intMax = 32'sh7FFF_FFFF;
	localparam intWord intMin = 32'sh8000_0000;

endpackage

/* common/fpuPkg.sv */
// Cluster level types: opcodes, tags, unit ids and the request and result buses.
// Every block that sits on the issue path or the result bus imports this.

package fpuPkg;

	import fpPkg::*;

	// ==================================================
	// Operation and routing codes
	// ==================================================

	// Opcode picks the function unit that takes the request
	typedef enum logic {
		opTrunc = 1'b0,
		opToInt = 1'b1
	} fpuOp;

	// Caller chosen tag, echoed back with the result
	typedef logic [3:0] fpuTag;

	// Source unit reported on the result bus
	typedef enum logic {
		unitTrunc = 1'b0,
		unitToInt = 1'b1
	} unitId;

	// ==================================================
	// Buses
	// ==================================================

	// One issue from the caller
	typedef struct packed {
		logic  valid;
		fpuOp  op;
		fpuTag tag;
		fpWord operand;
	} fpuReq;

	// Result leaving one function unit toward the arbiter
	typedef struct packed {
		logic        valid;
		fpuTag       tag;
		logic [31:0] value;
		logic        overflow;
	} unitResult;

	// Result on the shared output bus, tagged with the unit that made it
	typedef struct packed {
		logic        valid;
		unitId       src;
		fpuTag       tag;
		logic [31:0] value;
		logic        overflow;
	} fpuResult;

endpackage

/* fpu/fpToInt.sv */
// Float to signed 32-bit integer converter, rounding toward zero.
// Two pipeline stages, so two conversions can be in flight at once.
// Out of range values and NaN saturate and raise overflow.

`timescale 1ns/100ps

module fpToInt
	import fpPkg::*;
	import fpuPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      start,
	input  fpuTag     tagIn,
	input  fpWord     operand,
	output unitResult result
);

	// Outcome class decided in stage one
	typedef enum logic [1:0] {
		clsZero,
		clsNormal,
		clsSatPos,
		clsSatNeg
	} convClass;

	// Operand fields
	logic    opSign;
	expField opExp;
	manField opMan;

	// Stage one decode
	convClass      cls;
	logic          shLeft;
	logic [4:0]    shAmt;

	// Stage one registers
	logic          s1Valid;
	convClass      s1Cls;
	logic          s1Sign;
	logic [fracBits:0] s1Mant;
	logic          s1ShLeft;
	logic [4:0]    s1ShAmt;
	fpuTag         s1Tag;

	// Stage two datapath and registers
	logic [intBits-1:0] mag;
	intWord        convValue;
	logic          s2Valid;
	logic          s2Ovf;
	intWord        s2Value;
	fpuTag         s2Tag;

	assign opSign = operand[31];
	assign opExp  = operand[30:23];
	assign opMan  = operand[22:0];

	// ==================================================
	// Stage one: classify and compute shift
	// ==================================================

	always_comb begin
		int unbExp;
		unbExp = int'(opExp) - expBias;
		if (opExp == expSpecial && opMan != '0) begin
			// NaN goes to the positive limit regardless of sign
			cls = clsSatPos;
		end else if (unbExp < 0) begin
			cls = clsZero;
		end else if (unbExp >= intBits - 1) begin
			// Exactly -2^31 still fits, everything else at this scale saturates
			if (opSign && unbExp == intBits - 1 && opMan == '0) begin
				cls = clsNormal;
			end else begin
				cls = opSign ? clsSatNeg : clsSatPos;
			end
		end else begin
			cls = clsNormal;
		end

		// Mantissa has its point after bit fracBits, align it to bit zero
		if (unbExp <= fracBits) begin
			shLeft = 1'b0;
			shAmt  = 5'(fracBits - unbExp);
		end else begin
			shLeft = 1'b1;
			shAmt  = 5'(unbExp - fracBits);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		s1Cls    <= cls;
		s1Sign   <= opSign;
		// Restore the hidden leading one
		s1Mant   <= {1'b1, opMan};
		s1ShLeft <= shLeft;
		s1ShAmt  <= shAmt;
		s1Tag    <= tagIn;
	end

	// ==================================================
	// Stage two: shift, sign and saturate
	// ==================================================

	always_comb begin
		logic [intBits-1:0] wide;
		wide = {{(intBits - fracBits - 1){1'b0}}, s1Mant};
		mag  = s1ShLeft ? (wide << s1ShAmt) : (wide >> s1ShAmt);
		case (s1Cls)
			clsZero:   convValue = '0;
			clsSatPos: convValue = intMax;
			clsSatNeg: convValue = intMin;
			default:   convValue = s1Sign ? -intWord'(mag) : intWord'(mag);
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s2Valid <= 1'b0;
			s2Ovf   <= 1'b0;
		end else begin
			s2Valid <= s1Valid;
			s2Ovf   <= s1Valid && (s1Cls == clsSatPos || s1Cls == clsSatNeg);
		end
	end

	always_ff @(posedge clk) begin
		s2Value <= convValue;
		s2Tag   <= s1Tag;
	end

	assign result = '{valid: s2Valid, tag: s2Tag, value: s2Value, overflow: s2Ovf};

	// The flag only ever accompanies a real result
	ovfNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
		result.overflow |-> result.valid);

endmodule

/* fpu/fpTrunc.sv */
// Float truncation unit that drops every fraction bit below the binary point.
// One result per start strobe, registered one cycle later with its tag.

`timescale 1ns/100ps

module fpTrunc
	import fpPkg::*;
	import fpuPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      start,
	input  fpuTag     tagIn,
	input  fpWord     operand,
	output unitResult result
);

	// Operand fields
	logic    opSign;
	expField opExp;
	manField opMan;

	// Number of fraction bits that lie above the binary point
	logic [4:0] keepBits;
	manField    mask;
	fpWord      truncWord;

	// Output registers
	logic  resValid;
	fpuTag resTag;
	fpWord resWord;

	assign opSign = operand[31];
	assign opExp  = operand[30:23];
	assign opMan  = operand[22:0];

	// Only meaningful when the exponent is in the partial fraction range
	assign keepBits = 5'(int'(opExp) - expBias);

	// Ones in the top keepBits positions and zeros for the bits that get cut
	assign mask = ~({fracBits{1'b1}} >> keepBits);

	// ==================================================
	// Truncation
	// ==================================================

	always_comb begin
		if (opExp < expBias) begin
			// A magnitude below one always gives positive zero
			truncWord = '0;
		end else if (int'(opExp) >= expBias + fracBits) begin
			// Integers, infinity and NaN pass through as they are
			truncWord = operand;
		end else begin
			truncWord = {opSign, opExp, opMan & mask};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resValid <= 1'b0;
		end else begin
			resValid <= start;
		end
	end

	// Tag and truncated word ride along with the valid strobe
	always_ff @(posedge clk) begin
		resTag  <= tagIn;
		resWord <= truncWord;
	end

	assign result = '{valid: resValid, tag: resTag, value: resWord, overflow: 1'b0};

	// Every start yields a result exactly one cycle later, and nothing else does
	validFollowsStart: assert property (@(posedge clk)
		$past(rstN) |-> (result.valid == $past(start)));

endmodule

/* run.sh */
#!/bin/sh
# Compiles the cluster and its testbench with Verilator and runs the simulation.
# The result is judged by searching the log for the fail message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fpuClusterTb \
	-f sim.f -o fpuClusterSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fpuClusterSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -qF "** FAIL **" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "Simulator exited with status $runStatus"
	exit 1
fi

echo "Simulation passed"
exit 0

/* sim.f */
common/fpPkg.sv
common/fpuPkg.sv
fpu/fpTrunc.sv
fpu/fpToInt.sv
source/resultArbiter.sv
source/fpuCluster.sv
sim/fpuClusterTb.sv

/* sim/fpuClusterTb.sv */
// Testbench for the conversion cluster. Issues a table of operations with random
// spacing, then the same table back to back, and checks every result by its tag,
// its source unit and its order within that unit.

`timescale 1ns/100ps

module fpuClusterTb
	import fpPkg::*;
	import fpuPkg::*;
();

	// Small queues so that bursts push the cluster into busy
	localparam int tbDepth      = 2;
	localparam int busyTimeout  = 50;
	localparam int drainTimeout = 200;

	// One table row with the hand computed response
	typedef struct packed {
		fpWord       operand;
		fpuOp        op;
		logic [31:0] expValue;
		logic        expOvf;
	} vecEntry;

	logic     clk;
	logic     rstN;
	fpuReq    req;
	fpuResult result;
	logic     busy;

	vecEntry     vectors [$];
	// Issue numbers per unit with the oldest first
	int          truncOrder [$];
	int          toIntOrder [$];
	// Scoreboard indexed by tag
	int          pendingIssue [16];
	logic        pendingValid [16];
	int          issued;
	int          seen;
	logic        sawBusy;
	logic [31:0] lcgState;

	fpuCluster #(
		.queueDepth (tbDepth)
	) dut_i (
		.clk    (clk),
		.rstN   (rstN),
		.req    (req),
		.result (result),
		.busy   (busy)
	);

	always #2 clk = ~clk;

	// ==================================================
	// Helpers
	// ==================================================

	task automatic addVec(input fpWord operand, input fpuOp op, input logic [31:0] expValue,
		input logic expOvf);
		vectors.push_back(vecEntry'{operand: operand, op: op, expValue: expValue,
			expOvf: expOvf});
	endtask

	// Plain LCG that hands out only its stronger upper bits
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {17'd0, lcgState[30:16]};
	endfunction

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
			$display("** FAIL **");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic waitNotBusy();
		int cycles;
		cycles = 0;
		if (busy) begin
			sawBusy = 1'b1;
		end
		while (busy && cycles < busyTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			stopOnError("Timeout: busy stayed high and no new request could be issued");
		end
	endtask

	// Issues the next row tagged with the issue number modulo 16
	task automatic issueOne();
		fpuTag   tag;
		vecEntry row;
		waitNotBusy();
		tag = 4'(issued);
		row = vectors[issued % vectors.size()];
		if (pendingValid[tag]) begin
			stopOnError("A tag was still in flight when it came up for reuse");
		end else begin
			pendingIssue[tag] = issued;
			pendingValid[tag] = 1'b1;
			if (row.op == opTrunc) begin
				truncOrder.push_back(issued);
			end else begin
				toIntOrder.push_back(issued);
			end
			req.valid   = 1'b1;
			req.op      = row.op;
			req.tag     = tag;
			req.operand = row.operand;
			issued++;
			@(negedge clk);
			req.valid = 1'b0;
		end
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic loadTable();
		// 3.75, -2.5 and 1.0 lose their fraction
		addVec(32'h40700000, opTrunc, 32'h40400000, 1'b0);
		addVec(32'h40FCCCCD, opToInt, 32'h00000007, 1'b0);
		addVec(32'hC0200000, opTrunc, 32'hC0000000, 1'b0);
		addVec(32'hC0FCCCCD, opToInt, 32'hFFFFFFF9, 1'b0);
		addVec(32'h3F800000, opTrunc, 32'h3F800000, 1'b0);
		addVec(32'h3E99999A, opToInt, 32'h00000000, 1'b0);
		// Magnitudes below one and negative zero all become +0
		addVec(32'h3F333333, opTrunc, 32'h00000000, 1'b0);
		addVec(32'hBF333333, opTrunc, 32'h00000000, 1'b0);
		addVec(32'h80000000, opTrunc, 32'h00000000, 1'b0);
		// A run of conversions to fill the pipeline and the queue
		addVec(32'h4F32D05E, opToInt, 32'h7FFFFFFF, 1'b1);
		addVec(32'hCF32D05E, opToInt, 32'h80000000, 1'b1);
		addVec(32'h7FC00000, opToInt, 32'h7FFFFFFF, 1'b1);
		addVec(32'hCF000000, opToInt, 32'h80000000, 1'b0);
		// Integral values, infinity and NaN pass untouched
		addVec(32'h4E800000, opTrunc, 32'h4E800000, 1'b0);
		addVec(32'h7F800000, opTrunc, 32'h7F800000, 1'b0);
		addVec(32'h7FC00000, opTrunc, 32'h7FC00000, 1'b0);
		addVec(32'h4B000001, opTrunc, 32'h4B000001, 1'b0);
		// 8388607.5 keeps all but the lowest fraction bit
		addVec(32'h4AFFFFFF, opTrunc, 32'h4AFFFFFE, 1'b0);
		addVec(32'h42C98000, opTrunc, 32'h42C80000, 1'b0);
		addVec(32'h42C98000, opToInt, 32'h00000064, 1'b0);
		addVec(32'h3F800000, opToInt, 32'h00000001, 1'b0);
		addVec(32'hBFC00000, opToInt, 32'hFFFFFFFF, 1'b0);
		addVec(32'h4E800000, opToInt, 32'h40000000, 1'b0);
		addVec(32'h4B000001, opToInt, 32'h00800001, 1'b0);
		// 2^31 is one past the top and -inf is far below the bottom
		addVec(32'h4F000000, opToInt, 32'h7FFFFFFF, 1'b1);
		addVec(32'hFF800000, opToInt, 32'h80000000, 1'b1);
	endtask

	// ==================================================
	// Result monitor
	// ==================================================

	always @(negedge clk) begin
		int      num;
		int      front;
		vecEntry want;
		unitId   wantSrc;
		if (rstN && result.valid) begin
			if (!pendingValid[result.tag]) begin
				stopOnError("A result arrived with a tag that has no request in flight");
			end else begin
				num     = pendingIssue[result.tag];
				want    = vectors[num % vectors.size()];
				wantSrc = (want.op == opTrunc) ? unitTrunc : unitToInt;
				checkValue("result.src", 32'(result.src), 32'(wantSrc));
				// Results of one unit must leave in issue order
				if (wantSrc == unitTrunc) begin
					front = truncOrder.pop_front();
				end else begin
					front = toIntOrder.pop_front();
				end
				checkValue("issue order", front, num);
				checkValue("result.value", result.value, want.expValue);
				checkValue("result.overflow", 32'(result.overflow), 32'(want.expOvf));
				pendingValid[result.tag] = 1'b0;
				seen++;
			end
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int idle;
		int cycles;
		clk      = 1'b0;
		rstN     = 1'b0;
		req      = '0;
		issued   = 0;
		seen     = 0;
		sawBusy  = 1'b0;
		lcgState = 32'd89485;
		for (int t = 0; t < 16; t++) begin
			pendingIssue[t] = 0;
			pendingValid[t] = 1'b0;
		end
		loadTable();
		repeat (5) @(negedge clk);
		rstN = 1'b1;

		// Quiet bus and no busy before anything is issued
		repeat (3) begin
			@(negedge clk);
			checkValue("result.valid", 32'(result.valid), 32'd0);
			checkValue("busy", 32'(busy), 32'd0);
		end

		// First pass with 0 to 2 idle cycles between issues
		for (int i = 0; i < vectors.size(); i++) begin
			idle = int'(nextRand() % 32'd3);
			repeat (idle) @(negedge clk);
			issueOne();
		end

		// Second pass fully back to back so that busy does the throttling
		for (int i = 0; i < vectors.size(); i++) begin
			issueOne();
		end

		cycles = 0;
		while (seen < issued && cycles < drainTimeout) begin
			@(negedge clk);
			cycles++;
		end
		checkValue("busy", 32'(busy), 32'd0);
		if (!sawBusy) begin
			stopOnError("Busy never rose although back to back conversions overran the queue depth");
		end else if (seen == issued) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("Timeout: only %0d of %0d results arrived", seen, issued);
			$display("** FAIL **");
			$fatal(1, "Missing results");
		end
	end

endmodule

/* source/fpuCluster.sv */
// Top of the conversion cluster: steers each request by opcode to its unit.
// Both units report through the arbiter onto one result bus with a busy level.

`timescale 1ns/100ps

module fpuCluster
	import fpuPkg::*;
#(
	parameter int queueDepth = 4
) (
	input  logic     clk,
	input  logic     rstN,
	input  fpuReq    req,
	output fpuResult result,
	output logic     busy
);

	// Start strobes decoded from the opcode
	logic truncStart;
	logic toIntStart;

	// Per-unit results toward the arbiter
	unitResult truncRes;
	unitResult toIntRes;

	assign truncStart = req.valid && (req.op == opTrunc);
	assign toIntStart = req.valid && (req.op == opToInt);

	// ==================================================
	// Function units
	// ==================================================

	fpTrunc truncUnit (
		.clk     (clk),
		.rstN    (rstN),
		.start   (truncStart),
		.tagIn   (req.tag),
		.operand (req.operand),
		.result  (truncRes)
	);

	fpToInt toIntUnit (
		.clk     (clk),
		.rstN    (rstN),
		.start   (toIntStart),
		.tagIn   (req.tag),
		.operand (req.operand),
		.result  (toIntRes)
	);

	// Issue strobes double as the in-flight count increments
	resultArbiter #(
		.queueDepth (queueDepth)
	) resultArb (
		.clk         (clk),
		.rstN        (rstN),
		.truncIssue  (truncStart),
		.toIntIssue  (toIntStart),
		.truncResult (truncRes),
		.toIntResult (toIntRes),
		.result      (result),
		.busy        (busy)
	);

endmodule

/* source/resultArbiter.sv */
// Collects unit results into per-unit queues and drives the shared result bus.
// Grants round robin, one result per cycle, and raises busy when a unit is full.

`timescale 1ns/100ps

module resultArbiter
	import fpuPkg::*;
#(
	parameter int queueDepth = 4
) (
	input  logic      clk,
	input  logic      rstN,
	input  logic      truncIssue,
	input  logic      toIntIssue,
	input  unitResult truncResult,
	input  unitResult toIntResult,
	output fpuResult  result,
	output logic      busy
);

	localparam int ptrW = $clog2(queueDepth);
	localparam int cntW = $clog2(queueDepth + 1);

	// Units gathered into arrays indexed by unitId
	logic      issue  [2];
	unitResult unitIn [2];

	// Queue storage and pointers, one extra pointer bit tells full from empty
	unitResult mem   [2][queueDepth];
	logic [ptrW:0] wrPtr [2];
	logic [ptrW:0] rdPtr [2];
	logic [1:0]    empty;
	logic [1:0]    full;

	// Per-unit occupancy, in flight plus stored
	logic [cntW-1:0] cnt [2];

	// Arbitration
	unitResult head [2];
	logic [1:0] avail;
	logic [1:0] granted;
	logic       grantValid;
	unitId      grantSel;
	unitId      lastGrant;

	// Output registers
	logic        outValid;
	unitId       outSrc;
	fpuTag       outTag;
	logic [31:0] outValue;
	logic        outOvf;

	assign issue[unitTrunc]  = truncIssue;
	assign issue[unitToInt]  = toIntIssue;
	assign unitIn[unitTrunc] = truncResult;
	assign unitIn[unitToInt] = toIntResult;

	// ==================================================
	// Queue status and heads
	// ==================================================

	always_comb begin
		for (int u = 0; u < 2; u++) begin
			empty[u] = (wrPtr[u] == rdPtr[u]);
			full[u]  = (wrPtr[u][ptrW] != rdPtr[u][ptrW]) &&
				(wrPtr[u][ptrW-1:0] == rdPtr[u][ptrW-1:0]);
			// An empty queue hands the arriving result straight to the grant
			head[u]  = empty[u] ? unitIn[u] : mem[u][rdPtr[u][ptrW-1:0]];
			avail[u] = !empty[u] || unitIn[u].valid;
		end
	end

	// Round robin, alternate when both units have something waiting
	always_comb begin
		grantValid = |avail;
		if (avail[unitTrunc] && avail[unitToInt]) begin
			grantSel = (lastGrant == unitTrunc) ? unitToInt : unitTrunc;
		end else if (avail[unitToInt]) begin
			grantSel = unitToInt;
		end else begin
			grantSel = unitTrunc;
		end
		granted = '0;
		if (grantValid) begin
			granted[grantSel] = 1'b1;
		end
	end

	// ==================================================
	// Pointers, counters and storage
	// ==================================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int u = 0; u < 2; u++) begin
				wrPtr[u] <= '0;
				rdPtr[u] <= '0;
				cnt[u]   <= '0;
			end
			lastGrant <= unitToInt;
		end else begin
			for (int u = 0; u < 2; u++) begin
				// Every arrival is written, a bypassed one is skipped by the read side
				if (unitIn[u].valid) begin
					wrPtr[u] <= wrPtr[u] + 1'b1;
				end
				if (granted[u]) begin
					rdPtr[u] <= rdPtr[u] + 1'b1;
				end
				if (issue[u] && !granted[u]) begin
					cnt[u] <= cnt[u] + 1'b1;
				end else if (!issue[u] && granted[u]) begin
					cnt[u] <= cnt[u] - 1'b1;
				end
			end
			if (grantValid) begin
				lastGrant <= grantSel;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int u = 0; u < 2; u++) begin
			if (unitIn[u].valid) begin
				mem[u][wrPtr[u][ptrW-1:0]] <= unitIn[u];
			end
		end
	end

	// ==================================================
	// Output bus
	// ==================================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= grantValid;
		end
	end

	always_ff @(posedge clk) begin
		outSrc   <= grantSel;
		outTag   <= head[grantSel].tag;
		outValue <= head[grantSel].value;
		outOvf   <= head[grantSel].overflow;
	end

	assign result = '{valid: outValid, src: outSrc, tag: outTag, value: outValue,
		overflow: outOvf};

	// Counters cover every item a unit can still deliver
	assign busy = (cnt[unitTrunc] == cntW'(queueDepth)) ||
		(cnt[unitToInt] == cntW'(queueDepth));

	// Occupancy tracking must keep results from landing on a full queue
	noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		!((unitIn[0].valid && full[0]) || (unitIn[1].valid && full[1])));

	// Callers hold off while busy
	noIssueWhenBusy: assert property (@(posedge clk) disable iff (!rstN)
		(truncIssue || toIntIssue) |-> !busy);

endmodule
